// File: src/frontend_pkg.sv
`default_nettype none

package frontend_pkg;

  typedef logic [31:0] addr_t;    // byte address / pc
  typedef logic [31:0] word_t;    // instruction word or immediate
  typedef logic [4:0]  reg_idx_t; // architectural register number
  typedef logic [6:0]  opcode_t;  // major opcode field
  typedef logic [1:0]  ctr_t;     // two-bit saturating counter

  // RV32I major opcodes
  localparam opcode_t OPC_LOAD   = 7'b0000011;
  localparam opcode_t OPC_STORE  = 7'b0100011;
  localparam opcode_t OPC_BRANCH = 7'b1100011;
  localparam opcode_t OPC_JAL    = 7'b1101111;
  localparam opcode_t OPC_JALR   = 7'b1100111;
  localparam opcode_t OPC_AUIPC  = 7'b0010111;
  localparam opcode_t OPC_LUI    = 7'b0110111;
  localparam opcode_t OPC_OP_IMM = 7'b0010011;
  localparam opcode_t OPC_OP     = 7'b0110011;

  // R-type op and its I-type form share a code, use_imm tells them apart
  typedef enum logic [4:0] {
    OP_LB, OP_LBU, OP_LH, OP_LHU, OP_LW,
    OP_SB, OP_SH, OP_SW,
    OP_BEQ, OP_BNE, OP_BLT, OP_BGE, OP_BLTU, OP_BGEU,
    OP_JAL, OP_JALR, OP_AUIPC, OP_LUI,
    OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR,
    OP_SLL, OP_SRL, OP_SRA, OP_SLT, OP_SLTU,
    OP_INVALID = 5'd31
  } op_e;

  typedef struct packed {
    op_e      op;
    logic     is_branch; // conditional branches only
    logic     is_ls;
    logic     use_imm;
    reg_idx_t rd;
    reg_idx_t rs1;
    reg_idx_t rs2;
    word_t    imm;       // sign extended for its format
  } decoded_t;

  // what the fetch queue stores
  typedef struct packed {
    addr_t    pc;
    logic     pred_taken;
    decoded_t dec;
  } fetch_entry_t;

  // executed conditional branch report
  typedef struct packed {
    logic  valid;
    addr_t pc;
    logic  taken;
    logic  mispredict;
    addr_t target;
  } resolve_t;

  typedef struct packed {
    logic  valid;
    addr_t target;
  } jalr_done_t;

endpackage

`default_nettype wire

// File: src/inst_decoder.sv
`default_nettype none
`timescale 1ns/10ps

module inst_decoder (
  input  frontend_pkg::word_t    inst,
  output frontend_pkg::decoded_t dec
);
  import frontend_pkg::*;

  opcode_t    opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  word_t      imm_i;
  word_t      imm_s;
  word_t      imm_b;
  word_t      imm_u;
  word_t      imm_j;

  assign opcode = inst[6:0];
  assign funct3 = inst[14:12];
  assign funct7 = inst[31:25];

  // immediates per format
  assign imm_i = {{20{inst[31]}}, inst[31:20]};
  assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
  assign imm_b = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
  assign imm_u = {inst[31:12], 12'b0};
  assign imm_j = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

  always_comb begin
    dec    = '0;
    dec.op = OP_INVALID;
    case (opcode)
      OPC_LOAD: begin
        dec.is_ls   = 1'b1;
        dec.use_imm = 1'b1;
        dec.rd      = inst[11:7];
        dec.rs1     = inst[19:15];
        dec.imm     = imm_i;
        case (funct3)
          3'b000:  dec.op = OP_LB;
          3'b001:  dec.op = OP_LH;
          3'b010:  dec.op = OP_LW;
          3'b100:  dec.op = OP_LBU;
          3'b101:  dec.op = OP_LHU;
          default: ;
        endcase
      end
      OPC_STORE: begin
        dec.is_ls   = 1'b1;
        dec.use_imm = 1'b1;
        dec.rs1     = inst[19:15];
        dec.rs2     = inst[24:20];
        dec.imm     = imm_s;
        case (funct3)
          3'b000:  dec.op = OP_SB;
          3'b001:  dec.op = OP_SH;
          3'b010:  dec.op = OP_SW;
          default: ;
        endcase
      end
      OPC_BRANCH: begin
        dec.is_branch = 1'b1; // compares rs1 with rs2, imm is the offset
        dec.rs1       = inst[19:15];
        dec.rs2       = inst[24:20];
        dec.imm       = imm_b;
        case (funct3)
          3'b000:  dec.op = OP_BEQ;
          3'b001:  dec.op = OP_BNE;
          3'b100:  dec.op = OP_BLT;
          3'b101:  dec.op = OP_BGE;
          3'b110:  dec.op = OP_BLTU;
          3'b111:  dec.op = OP_BGEU;
          default: ;
        endcase
      end
      OPC_JAL: begin
        dec.op      = OP_JAL;
        dec.use_imm = 1'b1;
        dec.rd      = inst[11:7];
        dec.imm     = imm_j;
      end
      OPC_JALR: begin
        if (funct3 == 3'b000) dec.op = OP_JALR;
        dec.use_imm = 1'b1;
        dec.rd      = inst[11:7];
        dec.rs1     = inst[19:15];
        dec.imm     = imm_i;
      end
      OPC_AUIPC, OPC_LUI: begin
        dec.op      = (opcode == OPC_LUI) ? OP_LUI : OP_AUIPC;
        dec.use_imm = 1'b1;
        dec.rd      = inst[11:7];
        dec.imm     = imm_u;
      end
      OPC_OP_IMM: begin
        dec.use_imm = 1'b1;
        dec.rd      = inst[11:7];
        dec.rs1     = inst[19:15];
        dec.imm     = imm_i;
        case (funct3)
          3'b000: dec.op = OP_ADD;
          3'b010: dec.op = OP_SLT;
          3'b011: dec.op = OP_SLTU;
          3'b100: dec.op = OP_XOR;
          3'b110: dec.op = OP_OR;
          3'b111: dec.op = OP_AND;
          3'b001: if (funct7 == 7'b0000000) dec.op = OP_SLL;
          3'b101: begin
            if (funct7 == 7'b0000000) dec.op = OP_SRL;
            else if (funct7 == 7'b0100000) dec.op = OP_SRA;
          end
          default: ;
        endcase
        // shifts carry only the shift amount
        if (funct3 == 3'b001 || funct3 == 3'b101) dec.imm = {27'b0, inst[24:20]};
      end
      OPC_OP: begin
        dec.rd  = inst[11:7];
        dec.rs1 = inst[19:15];
        dec.rs2 = inst[24:20];
        if (funct7 == 7'b0000000) begin
          case (funct3)
            3'b000: dec.op = OP_ADD;
            3'b001: dec.op = OP_SLL;
            3'b010: dec.op = OP_SLT;
            3'b011: dec.op = OP_SLTU;
            3'b100: dec.op = OP_XOR;
            3'b101: dec.op = OP_SRL;
            3'b110: dec.op = OP_OR;
            3'b111: dec.op = OP_AND;
          endcase
        end else if (funct7 == 7'b0100000) begin
          if (funct3 == 3'b000) dec.op = OP_SUB;
          else if (funct3 == 3'b101) dec.op = OP_SRA;
        end
      end
      default: ;
    endcase
    // unknown encodings leave nothing behind
    if (dec.op == OP_INVALID) begin
      dec    = '0;
      dec.op = OP_INVALID;
    end
  end

endmodule

`default_nettype wire

// File: src/branch_predictor.sv
`default_nettype none
`timescale 1ns/10ps

module branch_predictor #(
  parameter int unsigned BHT_ENTRIES = 64
) (
  input  logic                   clk_in,
  input  logic                   rst_in,
  input  frontend_pkg::addr_t    pc,
  input  frontend_pkg::decoded_t dec,
  input  frontend_pkg::resolve_t resolve,
  output logic                   pred_taken
);
  import frontend_pkg::*;

  localparam int unsigned IDX_W = $clog2(BHT_ENTRIES);

  localparam ctr_t CTR_STRONG_NT = 2'd0;
  localparam ctr_t CTR_WEAK_NT   = 2'd1;
  localparam ctr_t CTR_STRONG_T  = 2'd3;

  ctr_t             bht [BHT_ENTRIES];
  logic [IDX_W-1:0] fetch_idx;
  logic [IDX_W-1:0] train_idx;
  ctr_t             train_ctr;

  // word index, bits 1:0 are always zero without compressed code
  assign fetch_idx = pc[IDX_W+1:2];
  assign train_idx = resolve.pc[IDX_W+1:2];
  assign train_ctr = bht[train_idx];

  // taken when counter is 2 or 3
  assign pred_taken = dec.is_branch && bht[fetch_idx][1];

  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      for (int i = 0; i < BHT_ENTRIES; i++) begin
        bht[i] <= CTR_WEAK_NT;
      end
    end else if (resolve.valid) begin
      // one step toward the real outcome, saturating
      if (resolve.taken) begin
        if (train_ctr != CTR_STRONG_T) bht[train_idx] <= train_ctr + 2'd1;
      end else begin
        if (train_ctr != CTR_STRONG_NT) bht[train_idx] <= train_ctr - 2'd1;
      end
    end
  end

  // low pc bits are dropped from the index
  a_resolve_aligned: assert property (
    @(posedge clk_in) disable iff (rst_in)
    resolve.valid |-> resolve.pc[1:0] == 2'b00
  );

endmodule

`default_nettype wire

// File: src/fetch_unit.sv
`default_nettype none
`timescale 1ns/10ps

module fetch_unit #(
  parameter frontend_pkg::addr_t RESET_PC = '0
) (
  input  logic                       clk_in,
  input  logic                       rst_in,
  input  logic                       rdy_in,
  input  logic                       inst_available,
  output frontend_pkg::addr_t        fetch_addr,
  input  frontend_pkg::decoded_t     dec,
  input  logic                       pred_taken,
  input  logic                       full,
  input  frontend_pkg::resolve_t     resolve,
  input  frontend_pkg::jalr_done_t   jalr_done,
  output logic                       enq,
  output frontend_pkg::fetch_entry_t enq_entry
);
  import frontend_pkg::*;

  addr_t pc_q;
  logic  halt_q;   // waiting for a jalr target
  logic  redirect;
  logic  is_jalr;
  addr_t next_pc;

  assign fetch_addr = pc_q;
  assign redirect   = resolve.valid && resolve.mispredict;
  assign is_jalr    = (dec.op == OP_JALR);

  // accepted this cycle, written into the queue at the edge
  assign enq = !rst_in && rdy_in && inst_available && !halt_q && !full && !redirect;

  assign enq_entry.pc         = pc_q;
  assign enq_entry.pred_taken = pred_taken;
  assign enq_entry.dec        = dec;

  always_comb begin
    if (dec.op == OP_JAL || (dec.is_branch && pred_taken)) begin
      next_pc = pc_q + dec.imm;
    end else if (is_jalr) begin
      next_pc = pc_q; // target is unknown, sit here until jalr_done
    end else begin
      next_pc = pc_q + 32'd4;
    end
  end

  // strobes last one cycle, so they are taken whatever rdy_in is
  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      pc_q   <= RESET_PC;
      halt_q <= 1'b0;
    end else if (jalr_done.valid) begin
      pc_q   <= jalr_done.target;
      halt_q <= 1'b0;
    end else if (redirect) begin
      pc_q <= resolve.target; // halt stays as it is
    end else if (enq) begin
      pc_q <= next_pc;
      if (is_jalr) halt_q <= 1'b1;
    end
  end

  a_no_redirect_clash: assert property (
    @(posedge clk_in) disable iff (rst_in)
    !(redirect && jalr_done.valid)
  );

  // a jalr target only comes back while fetch waits for it
  a_jalr_done_halted: assert property (
    @(posedge clk_in) disable iff (rst_in)
    jalr_done.valid |-> halt_q
  );

endmodule

`default_nettype wire

// File: src/fetch_queue.sv
`default_nettype none
`timescale 1ns/10ps

module fetch_queue #(
  parameter int unsigned FOQ_DEPTH = 8
) (
  input  logic                       clk_in,
  input  logic                       rst_in,
  input  logic                       rdy_in,
  input  logic                       enq,
  input  frontend_pkg::fetch_entry_t enq_entry,
  input  logic                       flush,
  input  logic                       deq,
  output logic                       full,
  output logic                       out_valid,
  output frontend_pkg::fetch_entry_t out_entry
);
  import frontend_pkg::*;

  localparam int unsigned PTR_W = $clog2(FOQ_DEPTH);
  localparam logic [PTR_W:0] CNT_FULL = (PTR_W+1)'(FOQ_DEPTH);

  fetch_entry_t     mem [FOQ_DEPTH];
  logic [PTR_W-1:0] head_q;
  logic [PTR_W-1:0] tail_q;
  logic [PTR_W:0]   count_q;
  logic             do_enq;
  logic             do_deq;

  assign full      = (count_q == CNT_FULL);
  assign out_valid = (count_q != '0);
  assign out_entry = mem[head_q]; // head is already a register

  assign do_enq = rdy_in && enq && !full;
  assign do_deq = rdy_in && deq && out_valid;

  always_ff @(posedge clk_in) begin
    if (rst_in || flush) begin
      head_q  <= '0;
      tail_q  <= '0;
      count_q <= '0;
    end else begin
      if (do_enq) tail_q <= tail_q + 1'b1; // wraps, depth is a power of two
      if (do_deq) head_q <= head_q + 1'b1;
      case ({do_enq, do_deq})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: ;
      endcase
    end
  end

  always_ff @(posedge clk_in) begin
    if (do_enq) mem[tail_q] <= enq_entry;
  end

  // fetch side must see full before it writes
  a_no_write_full: assert property (
    @(posedge clk_in) disable iff (rst_in)
    enq |-> !full
  );

  a_deq_when_valid: assert property (
    @(posedge clk_in) disable iff (rst_in)
    deq |-> out_valid
  );

endmodule

`default_nettype wire

// File: src/frontend_top.sv
`default_nettype none
`timescale 1ns/10ps

module frontend_top #(
  parameter int unsigned         BHT_ENTRIES = 64,
  parameter int unsigned         FOQ_DEPTH   = 8,
  parameter frontend_pkg::addr_t RESET_PC    = '0
) (
  input  logic                       clk_in,
  input  logic                       rst_in,
  input  logic                       rdy_in,
  input  logic                       inst_available,
  input  frontend_pkg::word_t        inst,
  output frontend_pkg::addr_t        fetch_addr,
  input  frontend_pkg::resolve_t     resolve,
  input  frontend_pkg::jalr_done_t   jalr_done,
  input  logic                       deq,
  output logic                       out_valid,
  output frontend_pkg::fetch_entry_t out_entry
);
  import frontend_pkg::*;

  decoded_t     dec;
  logic         pred_taken;
  logic         enq;
  fetch_entry_t enq_entry;
  logic         full;
  logic         flush;

  assign flush = resolve.valid && resolve.mispredict; // wrong path gone

  fetch_unit #(
    .RESET_PC (RESET_PC)
  ) fetch_unit_i (
    .clk_in         (clk_in),
    .rst_in         (rst_in),
    .rdy_in         (rdy_in),
    .inst_available (inst_available),
    .fetch_addr     (fetch_addr),
    .dec            (dec),
    .pred_taken     (pred_taken),
    .full           (full),
    .resolve        (resolve),
    .jalr_done      (jalr_done),
    .enq            (enq),
    .enq_entry      (enq_entry)
  );

  // memory answers for fetch_addr in the same cycle
  inst_decoder inst_decoder_i (
    .inst (inst),
    .dec  (dec)
  );

  branch_predictor #(
    .BHT_ENTRIES (BHT_ENTRIES)
  ) branch_predictor_i (
    .clk_in     (clk_in),
    .rst_in     (rst_in),
    .pc         (fetch_addr),
    .dec        (dec),
    .resolve    (resolve),
    .pred_taken (pred_taken)
  );

  fetch_queue #(
    .FOQ_DEPTH (FOQ_DEPTH)
  ) fetch_queue_i (
    .clk_in    (clk_in),
    .rst_in    (rst_in),
    .rdy_in    (rdy_in),
    .enq       (enq),
    .enq_entry (enq_entry),
    .flush     (flush),
    .deq       (deq),
    .full      (full),
    .out_valid (out_valid),
    .out_entry (out_entry)
  );

endmodule

`default_nettype wire

// File: bench/frontend_tb.sv
`default_nettype none
`timescale 1ns/10ps

module frontend_tb;
  import frontend_pkg::*;

  localparam int unsigned BHT_ENTRIES = 64;
  localparam int unsigned FOQ_DEPTH   = 8;
  localparam addr_t       RESET_PC    = '0;
  localparam int unsigned IDX_W       = $clog2(BHT_ENTRIES);
  localparam int unsigned MEM_WORDS   = 256;
  localparam int unsigned NUM_DEQ     = 3000;
  localparam int unsigned MAX_CYCLES  = NUM_DEQ * 20 / 3; // about 6.7 cycles per entry
  localparam int unsigned PERIOD_NS   = 100;

  logic         clk_in;
  logic         rst_in;
  logic         rdy_in;
  logic         inst_available;
  word_t        inst;
  addr_t        fetch_addr;
  resolve_t     resolve;
  jalr_done_t   jalr_done;
  logic         deq;
  logic         out_valid;
  fetch_entry_t out_entry;

  word_t    mem     [MEM_WORDS];
  decoded_t exp_dec [MEM_WORDS];   // decode expected for each memory word
  ctr_t     ctr     [BHT_ENTRIES]; // model of the counter table
  addr_t    exp_pc;
  logic     jalr_pending;
  int       jalr_wait;
  addr_t    last_br_pc;
  logic     redirect_sent;         // strobe with a new pc went out last cycle
  addr_t    redirect_pc;
  int       deq_count;
  int       deq_pct;
  int       cycle;

  always #(PERIOD_NS / 2) clk_in = ~clk_in;

  assign inst = mem[fetch_addr[9:2]]; // memory answers in the same cycle

  frontend_top #(
    .BHT_ENTRIES (BHT_ENTRIES),
    .FOQ_DEPTH   (FOQ_DEPTH),
    .RESET_PC    (RESET_PC)
  ) frontend_top_i (
    .clk_in         (clk_in),
    .rst_in         (rst_in),
    .rdy_in         (rdy_in),
    .inst_available (inst_available),
    .inst           (inst),
    .fetch_addr     (fetch_addr),
    .resolve        (resolve),
    .jalr_done      (jalr_done),
    .deq            (deq),
    .out_valid      (out_valid),
    .out_entry      (out_entry)
  );

  function automatic logic roll_percent(input int unsigned pct);
    return $urandom_range(0, 99) < pct;
  endfunction

  function automatic addr_t random_target();
    return addr_t'($urandom_range(0, MEM_WORDS - 1)) << 2;
  endfunction

  task automatic report_mismatch(input string msg);
    $display("CHECK FAILED at %0t: %s", $time, msg);
    $display("Checks failed");
    $fatal(1);
  endtask

  // builds one legal word together with the decode it must give
  task automatic make_inst(input int idx, output word_t w, output decoded_t d);
    int          kind;
    int          tgt;
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [2:0]  f3;
    logic [6:0]  f7;
    logic [4:0]  opv;
    logic [11:0] i12;
    logic [19:0] u20;
    logic [20:0] off;
    rd  = 5'($urandom);
    rs1 = 5'($urandom);
    rs2 = 5'($urandom);
    i12 = 12'($urandom);
    u20 = 20'($urandom);
    tgt = idx + int'($urandom_range(0, 16)) - 8; // short hops, stays in the array
    if (tgt < 0) tgt = 0;
    if (tgt > int'(MEM_WORDS) - 1) tgt = MEM_WORDS - 1;
    off  = 21'((tgt - idx) * 4);
    kind = int'($urandom_range(0, 99));
    if (idx == int'(MEM_WORDS) - 1) begin
      kind = 0;
      off  = 21'(-4 * idx); // last word jumps back to the start
    end
    d = '0;
    if (kind < 8) begin
      w       = {off[20], off[10:1], off[11], off[19:12], rd, OPC_JAL};
      d.op    = OP_JAL;
      d.rd    = rd;
      d.imm   = {{11{off[20]}}, off};
      d.use_imm = 1'b1;
    end else if (kind < 16) begin
      w       = {i12, rs1, 3'b000, rd, OPC_JALR};
      d.op    = OP_JALR;
      d.rd    = rd;
      d.rs1   = rs1;
      d.imm   = {{20{i12[11]}}, i12};
      d.use_imm = 1'b1;
    end else if (kind < 31) begin
      case ($urandom_range(0, 5))
        0:       {f3, opv} = {3'd0, OP_BEQ};
        1:       {f3, opv} = {3'd1, OP_BNE};
        2:       {f3, opv} = {3'd4, OP_BLT};
        3:       {f3, opv} = {3'd5, OP_BGE};
        4:       {f3, opv} = {3'd6, OP_BLTU};
        default: {f3, opv} = {3'd7, OP_BGEU};
      endcase
      w           = {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], OPC_BRANCH};
      d.op        = op_e'(opv);
      d.is_branch = 1'b1;
      d.rs1       = rs1;
      d.rs2       = rs2;
      d.imm       = {{11{off[20]}}, off};
    end else if (kind < 46) begin
      case ($urandom_range(0, 4))
        0:       {f3, opv} = {3'd0, OP_LB};
        1:       {f3, opv} = {3'd1, OP_LH};
        2:       {f3, opv} = {3'd2, OP_LW};
        3:       {f3, opv} = {3'd4, OP_LBU};
        default: {f3, opv} = {3'd5, OP_LHU};
      endcase
      w         = {i12, rs1, f3, rd, OPC_LOAD};
      d.op      = op_e'(opv);
      d.is_ls   = 1'b1;
      d.use_imm = 1'b1;
      d.rd      = rd;
      d.rs1     = rs1;
      d.imm     = {{20{i12[11]}}, i12};
    end else if (kind < 56) begin
      case ($urandom_range(0, 2))
        0:       {f3, opv} = {3'd0, OP_SB};
        1:       {f3, opv} = {3'd1, OP_SH};
        default: {f3, opv} = {3'd2, OP_SW};
      endcase
      w         = {i12[11:5], rs2, rs1, f3, i12[4:0], OPC_STORE};
      d.op      = op_e'(opv);
      d.is_ls   = 1'b1;
      d.use_imm = 1'b1;
      d.rs1     = rs1;
      d.rs2     = rs2;
      d.imm     = {{20{i12[11]}}, i12};
    end else if (kind < 62) begin
      w         = {u20, rd, (kind < 59) ? OPC_LUI : OPC_AUIPC};
      d.op      = (kind < 59) ? OP_LUI : OP_AUIPC;
      d.use_imm = 1'b1;
      d.rd      = rd;
      d.imm     = {u20, 12'b0};
    end else if (kind < 81) begin
      d.imm = {{20{i12[11]}}, i12};
      case ($urandom_range(0, 8))
        0:       {f3, opv} = {3'd0, OP_ADD};
        1:       {f3, opv} = {3'd2, OP_SLT};
        2:       {f3, opv} = {3'd3, OP_SLTU};
        3:       {f3, opv} = {3'd4, OP_XOR};
        4:       {f3, opv} = {3'd6, OP_OR};
        5:       {f3, opv} = {3'd7, OP_AND};
        6:       {f3, opv, i12} = {3'd1, OP_SLL, 7'h00, rs2};
        7:       {f3, opv, i12} = {3'd5, OP_SRL, 7'h00, rs2};
        default: {f3, opv, i12} = {3'd5, OP_SRA, 7'h20, rs2};
      endcase
      if (f3 == 3'd1 || f3 == 3'd5) d.imm = {27'b0, rs2}; // shift amount only
      w         = {i12, rs1, f3, rd, OPC_OP_IMM};
      d.op      = op_e'(opv);
      d.use_imm = 1'b1;
      d.rd      = rd;
      d.rs1     = rs1;
    end else begin
      case ($urandom_range(0, 9))
        0:       {f7, f3, opv} = {7'h00, 3'd0, OP_ADD};
        1:       {f7, f3, opv} = {7'h20, 3'd0, OP_SUB};
        2:       {f7, f3, opv} = {7'h00, 3'd1, OP_SLL};
        3:       {f7, f3, opv} = {7'h00, 3'd2, OP_SLT};
        4:       {f7, f3, opv} = {7'h00, 3'd3, OP_SLTU};
        5:       {f7, f3, opv} = {7'h00, 3'd4, OP_XOR};
        6:       {f7, f3, opv} = {7'h00, 3'd5, OP_SRL};
        7:       {f7, f3, opv} = {7'h20, 3'd5, OP_SRA};
        8:       {f7, f3, opv} = {7'h00, 3'd6, OP_OR};
        default: {f7, f3, opv} = {7'h00, 3'd7, OP_AND};
      endcase
      w     = {f7, rs2, rs1, f3, rd, OPC_OP};
      d.op  = op_e'(opv);
      d.rd  = rd;
      d.rs1 = rs1;
      d.rs2 = rs2;
    end
  endtask

  task automatic train_counter(input addr_t pc, input logic taken);
    ctr_t c;
    c = ctr[pc[IDX_W+1:2]];
    if (taken && c != 2'd3) begin
      ctr[pc[IDX_W+1:2]] = c + 2'd1;
    end else if (!taken && c != 2'd0) begin
      ctr[pc[IDX_W+1:2]] = c - 2'd1;
    end
  endtask

  // compares the head entry with the model, then moves the model on
  task automatic check_entry(input fetch_entry_t e);
    decoded_t d;
    logic     pred;
    d    = exp_dec[exp_pc[9:2]];
    pred = d.is_branch && ctr[exp_pc[IDX_W+1:2]] >= 2'd2;
    assert (e.pc == exp_pc)
      else report_mismatch($sformatf("entry pc %h, expected %h", e.pc, exp_pc));
    assert (e.dec == d)
      else report_mismatch($sformatf("decode at %h is %h, expected %h", e.pc, e.dec, d));
    assert (e.pred_taken == pred)
      else report_mismatch($sformatf("pred_taken at %h is %b", e.pc, e.pred_taken));
    if (d.is_branch) last_br_pc = exp_pc;
    if (d.op == OP_JAL || (d.is_branch && pred)) begin
      exp_pc = exp_pc + d.imm;
    end else if (d.op == OP_JALR) begin
      jalr_pending = 1'b1;
      jalr_wait    = $urandom_range(2, 6);
    end else begin
      exp_pc = exp_pc + 32'd4;
    end
  endtask

  task automatic drive_cycle();
    logic  jalr_sent;
    logic  at_jalr;
    logic  mispredict;
    logic  taken;
    addr_t tgt;
    jalr_sent = 1'b0;
    deq       = 1'b0;
    resolve   = '0;
    jalr_done = '0;
    cycle++;
    if (cycle % 256 == 0) deq_pct = $urandom_range(20, 100); // droughts and bursts
    assert (!(jalr_pending && out_valid))
      else report_mismatch("entry showed up before the jalr target was sent");
    // new pc is on fetch_addr one cycle after the strobe
    assert (!redirect_sent || fetch_addr == redirect_pc)
      else report_mismatch($sformatf("fetch_addr %h after redirect, expected %h",
                                     fetch_addr, redirect_pc));
    redirect_sent = 1'b0;
    if (jalr_pending) begin
      jalr_wait--;
      if (jalr_wait == 0) begin
        tgt              = random_target();
        jalr_done.valid  = 1'b1;
        jalr_done.target = tgt;
        exp_pc           = tgt;
        jalr_pending     = 1'b0;
        jalr_sent        = 1'b1;
        redirect_sent    = 1'b1;
        redirect_pc      = tgt;
      end
    end
    rdy_in         = roll_percent(90);
    inst_available = roll_percent(80);
    // pc sits on a jalr word while the halt may be set
    at_jalr = (exp_dec[fetch_addr[9:2]].op == OP_JALR);
    if (!rdy_in && !jalr_sent && !at_jalr && roll_percent(30)) begin
      mispredict = roll_percent(40);
      taken      = roll_percent(50);
      tgt        = random_target();
      // plain resolve only over an empty queue, queued predictions stay valid
      if (mispredict || !out_valid) begin
        resolve.valid      = 1'b1;
        resolve.pc         = last_br_pc;
        resolve.taken      = taken;
        resolve.mispredict = mispredict;
        resolve.target     = tgt;
        train_counter(last_br_pc, taken);
        if (mispredict) begin
          exp_pc        = tgt; // queue flushed at the edge
          redirect_sent = 1'b1;
          redirect_pc   = tgt;
        end
      end
    end
    if (rdy_in && out_valid && roll_percent(deq_pct)) begin
      deq = 1'b1;
      check_entry(out_entry);
      deq_count++;
    end
  endtask

  initial begin
    clk_in         = 1'b0;
    rst_in         = 1'b1;
    rdy_in         = 1'b0;
    inst_available = 1'b0;
    resolve        = '0;
    jalr_done      = '0;
    deq            = 1'b0;
    void'($urandom(32'hc767));
    for (int i = 0; i < int'(MEM_WORDS); i++) begin
      make_inst(i, mem[i], exp_dec[i]);
    end
    for (int i = 0; i < int'(BHT_ENTRIES); i++) begin
      ctr[i] = 2'd1; // weakly not taken
    end
    exp_pc        = RESET_PC;
    jalr_pending  = 1'b0;
    jalr_wait     = 0;
    last_br_pc    = '0;
    redirect_sent = 1'b0;
    redirect_pc   = '0;
    deq_count     = 0;
    deq_pct       = 50;
    cycle         = 0;
    repeat (10) @(posedge clk_in);
    #1;
    rst_in = 1'b0;
    assert (!out_valid) else report_mismatch("out_valid high right after reset");
    assert (fetch_addr == RESET_PC)
      else report_mismatch($sformatf("fetch_addr %h after reset, expected %h",
                                     fetch_addr, RESET_PC));
    while (deq_count < int'(NUM_DEQ)) begin
      drive_cycle();
      @(posedge clk_in);
      #1;
    end
    $display("All checks passed");
    $finish;
  end

  initial begin
    #(MAX_CYCLES * PERIOD_NS);
    $display("watchdog expired, only %0d of %0d entries dequeued", deq_count, NUM_DEQ);
    $display("Checks failed");
    $fatal(1);
  end

endmodule

`default_nettype wire

// File: verilog.f
src/frontend_pkg.sv
src/inst_decoder.sv
src/branch_predictor.sv
src/fetch_unit.sv
src/fetch_queue.sv
src/frontend_top.sv
bench/frontend_tb.sv

// File: Bender.yml
package:
  name: frontend

sources:
  - src/frontend_pkg.sv
  - src/inst_decoder.sv
  - src/branch_predictor.sv
  - src/fetch_unit.sv
  - src/fetch_queue.sv
  - src/frontend_top.sv
  - target: test
    files:
      - bench/frontend_tb.sv
